// ==== verification/ppc_core_patterns.txt ====
// Columns: test number, instruction word, destination GPR, expected value, no-result flag
// All hex; a flag of 1 means the instruction must not reach the result bus
1 38201234 01 00001234 0 // addi r1,r0,0x1234
1 3840FFFE 02 FFFFFFFE 0 // addi r2,r0,-2
1 38618000 03 FFFF9234 0 // addi r3,r1,0x8000
1 6024F00F 04 0000F23F 0 // ori r4,r1,0xF00F
2 7CA11214 05 00001232 0 // add r5,r1,r2
2 7CC11850 06 FFFF8000 0 // subf r6,r1,r3
2 7C672038 07 00009234 0 // and r7,r3,r4
2 7C482378 08 FFFFFFFF 0 // or r8,r2,r4
2 7C692278 09 FFFF600B 0 // xor r9,r3,r4
3 39400005 0A 00000005 0 // addi r10,r0,5
3 7D6A5214 0B 0000000A 0 // add r11,r10,r10
3 7D6C5278 0C 0000000F 0 // xor r12,r11,r10
3 7DAC5850 0D FFFFFFFB 0 // subf r13,r12,r11
4 39C00111 0E 00000111 0 // addi r14,r0,0x111
4 39C00222 0E 00000222 0 // addi r14,r0,0x222
4 7DEE7214 0F 00000444 0 // add r15,r14,r14
5 3A000001 10 00000001 0 // addi r16,r0,1
5 3A300001 11 00000002 0 // addi r17,r16,1
5 3A510001 12 00000003 0 // addi r18,r17,1
5 3A720001 13 00000004 0 // addi r19,r18,1
5 3A930001 14 00000005 0 // addi r20,r19,1
5 3AB40001 15 00000006 0 // addi r21,r20,1
6 4BFFFFFC 00 00000000 1 // b -4, not supported
6 62B600F0 16 000000F6 0 // ori r22,r21,0xF0
6 7ED72038 17 00000036 0 // and r23,r22,r4

// ==== files.f ====
hdl/ppc_isa_pkg.sv
hdl/ppc_core_pkg.sv
hdl/instruction_decode.sv
hdl/dispatcher.sv
hdl/gp_reg_file.sv
hdl/fx_unit.sv
hdl/write_back_arbiter.sv
hdl/ppc_core.sv
verification/ppc_core_asserts.sv
verification/tb_ppc_core.sv

// ==== Bender.yml ====
package:
  name: ppc_core

sources:
  - hdl/ppc_isa_pkg.sv
  - hdl/ppc_core_pkg.sv
  - hdl/instruction_decode.sv
  - hdl/dispatcher.sv
  - hdl/gp_reg_file.sv
  - hdl/fx_unit.sv
  - hdl/write_back_arbiter.sv
  - hdl/ppc_core.sv
  - target: simulation
    files:
      - verification/ppc_core_asserts.sv
      - verification/tb_ppc_core.sv

// ==== verification/tb_ppc_core.sv ====
// Testbench for the core with pattern-driven stimulus, result bus scoreboard and timeout
`timescale 1ns/100ps

module tb_ppc_core;
    import ppc_isa_pkg::*;
    import ppc_core_pkg::*;

    localparam int PATTERN_COUNT = 25;
    localparam int CYCLE_LIMIT = 50 * PATTERN_COUNT;
    // Test whose chain fills the add unit's stations
    localparam int STALL_TEST = 5;

    logic clk;
    logic rst_n;
    logic instruction_valid;
    logic instruction_ready;
    word_t instruction;
    logic result_valid;
    result_t result;

    // Five columns per pattern line
    logic [31:0] pattern_mem [0:PATTERN_COUNT*5-1];
    int exp_test [PATTERN_COUNT];
    word_t exp_word [PATTERN_COUNT];
    gpr_addr_t exp_dst [PATTERN_COUNT];
    word_t exp_value [PATTERN_COUNT];
    logic exp_none [PATTERN_COUNT];
    logic exp_pending [PATTERN_COUNT];

    int error_count;
    int check_count;
    int stall_count;
    int test_count;
    int cycle_count = 0;

    ppc_core i_ppc_core (
        .clk(clk),
        .rst_n(rst_n),
        .instruction_valid(instruction_valid),
        .instruction_ready(instruction_ready),
        .instruction(instruction),
        .result_valid(result_valid),
        .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int count_pending(input int test_id);
        int n;
        n = 0;
        for (int i = 0; i < PATTERN_COUNT; i++) begin
            if (exp_pending[i] && exp_test[i] == test_id) begin
                n++;
            end
        end
        return n;
    endfunction

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_instruction(input word_t word, input bit allow_gap);
        int gap;
        begin
            gap = (allow_gap && $urandom % 4 == 0) ? 1 : 0;
            repeat (gap) @(negedge clk);
            instruction_valid = 1'b1;
            instruction = word;
            while (!instruction_ready) begin
                @(negedge clk);
            end
            @(negedge clk);
            instruction_valid = 1'b0;
        end
    endtask

    task automatic wait_test_done(input int test_id);
        begin
            @(posedge clk);
            while (count_pending(test_id) != 0) begin
                @(posedge clk);
            end
            @(negedge clk);
        end
    endtask

    // Cycles in which the core refuses new instructions
    always @(negedge clk) begin
        if (rst_n && !instruction_ready) begin
            stall_count++;
        end
    end

    // Results may arrive in any order within a test
    always @(negedge clk) begin : scoreboard
        int hit;
        int near;
        if (rst_n && result_valid) begin
            hit = -1;
            near = -1;
            for (int i = 0; i < PATTERN_COUNT; i++) begin
                if (exp_pending[i] && exp_dst[i] == result.dst) begin
                    if (hit < 0 && exp_value[i] == result.value) begin
                        hit = i;
                    end
                    if (near < 0) begin
                        near = i;
                    end
                end
            end
            check_count++;
            if (hit >= 0) begin
                exp_pending[hit] = 1'b0;
            end else if (near >= 0) begin
                $display("CHECK FAILED at %0t: result.value for r%0d expected %h got %h",
                         $time, result.dst, exp_value[near], result.value);
                error_count++;
                exp_pending[near] = 1'b0;
            end else begin
                $display("Unexpected result on the bus at %0t for r%0d with value %h",
                         $time, result.dst, result.value);
                error_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with results still outstanding", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        int idx;
        int test_id;
        int test_errors;
        void'($urandom(32'hf1a0));
        error_count = 0;
        check_count = 0;
        stall_count = 0;
        test_count = 0;
        rst_n = 1'b0;
        instruction_valid = 1'b0;
        instruction = '0;
        $readmemh("verification/ppc_core_patterns.txt", pattern_mem);
        for (int i = 0; i < PATTERN_COUNT; i++) begin
            exp_test[i] = int'(pattern_mem[5*i]);
            exp_word[i] = pattern_mem[5*i+1];
            exp_dst[i] = pattern_mem[5*i+2][4:0];
            exp_value[i] = pattern_mem[5*i+3];
            exp_none[i] = pattern_mem[5*i+4][0];
            exp_pending[i] = 1'b0;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        idx = 0;
        while (idx < PATTERN_COUNT) begin
            test_id = exp_test[idx];
            test_errors = error_count;
            stall_count = 0;
            for (int i = idx; i < PATTERN_COUNT; i++) begin
                if (exp_test[i] == test_id) begin
                    exp_pending[i] = !exp_none[i];
                end
            end
            // Back-to-back issue so the add unit runs out of stations
            while (idx < PATTERN_COUNT && exp_test[idx] == test_id) begin
                send_instruction(exp_word[idx], test_id != STALL_TEST);
                idx++;
            end
            wait_test_done(test_id);
            if (test_id == STALL_TEST && stall_count == 0) begin
                $display("Test %0d never saw instruction_ready drop with a full unit",
                         test_id);
                error_count++;
            end
            test_count++;
            $display("Test %0d done: %0d errors, %0d stall cycles",
                     test_id, error_count - test_errors, stall_count);
        end
        // Idle tail so a stray result would still be caught
        repeat (10) @(negedge clk);
        $display("Ran %0d tests, %0d result checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verification/ppc_core_asserts.sv ====
// Concurrent assertions on the instruction handshake and the result bus, with bind
`timescale 1ns/100ps

module ppc_core_asserts (
    input logic clk,
    input logic rst_n,
    input logic instruction_valid,
    input logic instruction_ready,
    input ppc_isa_pkg::word_t instruction,
    input logic tag_enable,
    input ppc_core_pkg::rs_id_t tag_rs_id,
    input logic result_valid,
    input ppc_core_pkg::result_t result
);
    import ppc_core_pkg::*;

    // Station IDs handed out at dispatch and not yet seen on the result bus
    logic [2*RS_DEPTH-1:0] in_flight;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= '0;
        end else begin
            if (result_valid) begin
                in_flight[result.rs_id] <= 1'b0;
            end
            // A station reused in the cycle its old result is on the bus
            if (tag_enable) begin
                in_flight[tag_rs_id] <= 1'b1;
            end
        end
    end

    // A waiting instruction stays offered and unchanged
    instruction_held: assert property (@(posedge clk) disable iff (!rst_n)
        instruction_valid && !instruction_ready |=> instruction_valid && $stable(instruction))
        else $error("instruction changed while waiting for ready");

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !result_valid)
        else $error("result_valid high during reset");

    rs_id_dispatched: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> in_flight[result.rs_id])
        else $error("station ID %0d on the result bus has no dispatched instruction",
                    result.rs_id);

endmodule

bind ppc_core ppc_core_asserts i_ppc_core_asserts (
    .clk(clk),
    .rst_n(rst_n),
    .instruction_valid(instruction_valid),
    .instruction_ready(instruction_ready),
    .instruction(instruction),
    .tag_enable(tag_enable),
    .tag_rs_id(tag_rs_id),
    .result_valid(result_valid),
    .result(result)
);

// ==== hdl/ppc_core.sv ====
// Core top level with decode, dispatch, GPR file, add and logical units and arbiter
`timescale 1ns/100ps

module ppc_core (
    input  logic clk,
    input  logic rst_n,
    input  logic instruction_valid,
    output logic instruction_ready,
    input  ppc_isa_pkg::word_t instruction,
    output logic result_valid,
    output ppc_core_pkg::result_t result
);
    import ppc_isa_pkg::*;
    import ppc_core_pkg::*;

    logic decode_valid;
    logic decode_ready;
    decode_t decode;

    gpr_addr_t rd_addr [2];
    operand_t rd_operand [2];
    logic tag_enable;
    gpr_addr_t tag_addr;
    rs_id_t tag_rs_id;

    logic issue_valid [UNIT_COUNT];
    logic issue_ready [UNIT_COUNT];
    issue_t issue;
    rs_id_t id_taken [UNIT_COUNT];

    logic unit_valid [UNIT_COUNT];
    logic unit_ready [UNIT_COUNT];
    result_t unit_result [UNIT_COUNT];

    instruction_decode i_instruction_decode (
        .clk(clk),
        .rst_n(rst_n),
        .instruction_valid(instruction_valid),
        .instruction_ready(instruction_ready),
        .instruction(instruction),
        .decode_valid(decode_valid),
        .decode_ready(decode_ready),
        .decode(decode)
    );

    dispatcher i_dispatcher (
        .decode_valid(decode_valid),
        .decode_ready(decode_ready),
        .decode(decode),
        .rd_addr(rd_addr),
        .rd_operand(rd_operand),
        .tag_enable(tag_enable),
        .tag_addr(tag_addr),
        .tag_rs_id(tag_rs_id),
        .result_valid(result_valid),
        .result(result),
        .issue_valid(issue_valid),
        .issue_ready(issue_ready),
        .issue(issue),
        .id_taken(id_taken)
    );

    gp_reg_file i_gp_reg_file (
        .clk(clk),
        .rst_n(rst_n),
        .rd_addr(rd_addr),
        .rd_operand(rd_operand),
        .tag_enable(tag_enable),
        .tag_addr(tag_addr),
        .tag_rs_id(tag_rs_id),
        .result_valid(result_valid),
        .result(result)
    );

    fx_unit #(
        .RS_OFFSET(ADD_RS_OFFSET),
        .UNIT(UNIT_ADD)
    ) i_add_unit (
        .clk(clk),
        .rst_n(rst_n),
        .issue_valid(issue_valid[0]),
        .issue_ready(issue_ready[0]),
        .issue(issue),
        .id_taken(id_taken[0]),
        .result_valid(result_valid),
        .result(result),
        .out_valid(unit_valid[0]),
        .out_ready(unit_ready[0]),
        .out_result(unit_result[0])
    );

    fx_unit #(
        .RS_OFFSET(LOG_RS_OFFSET),
        .UNIT(UNIT_LOG)
    ) i_log_unit (
        .clk(clk),
        .rst_n(rst_n),
        .issue_valid(issue_valid[1]),
        .issue_ready(issue_ready[1]),
        .issue(issue),
        .id_taken(id_taken[1]),
        .result_valid(result_valid),
        .result(result),
        .out_valid(unit_valid[1]),
        .out_ready(unit_ready[1]),
        .out_result(unit_result[1])
    );

    write_back_arbiter i_write_back_arbiter (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(unit_valid),
        .in_ready(unit_ready),
        .in_result(unit_result),
        .result_valid(result_valid),
        .result(result)
    );

endmodule

// ==== hdl/write_back_arbiter.sv ====
// Fixed-priority write-back arbiter driving the registered result bus
`timescale 1ns/100ps

module write_back_arbiter (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid [ppc_core_pkg::UNIT_COUNT],
    output logic in_ready [ppc_core_pkg::UNIT_COUNT],
    input  ppc_core_pkg::result_t in_result [ppc_core_pkg::UNIT_COUNT],
    output logic result_valid,
    output ppc_core_pkg::result_t result
);
    import ppc_core_pkg::*;

    logic taken;
    result_t granted;

    // Lowest index wins
    always_comb begin
        taken = 1'b0;
        granted = in_result[0];
        for (int u = 0; u < UNIT_COUNT; u++) begin
            in_ready[u] = in_valid[u] && !taken;
            if (in_ready[u]) begin
                granted = in_result[u];
            end
            taken = taken || in_valid[u];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (taken) begin
            result <= granted;
        end
    end

endmodule

// ==== hdl/fx_unit.sv ====
// Reservation station pool with bus snoop, oldest-ready issue and one-cycle ALU
`timescale 1ns/100ps

module fx_unit #(
    parameter ppc_core_pkg::rs_id_t RS_OFFSET = ppc_core_pkg::ADD_RS_OFFSET,
    parameter ppc_core_pkg::unit_e UNIT = ppc_core_pkg::UNIT_ADD
) (
    input  logic clk,
    input  logic rst_n,
    input  logic issue_valid,
    output logic issue_ready,
    input  ppc_core_pkg::issue_t issue,
    output ppc_core_pkg::rs_id_t id_taken,
    input  logic result_valid,
    input  ppc_core_pkg::result_t result,
    output logic out_valid,
    input  logic out_ready,
    output ppc_core_pkg::result_t out_result
);
    import ppc_isa_pkg::*;
    import ppc_core_pkg::*;

    typedef logic [$clog2(RS_DEPTH)-1:0] idx_t;

    issue_t station [RS_DEPTH];
    logic busy [RS_DEPTH];
    logic issued [RS_DEPTH];
    // Age order, 0 is the oldest occupied station
    idx_t rank [RS_DEPTH];
    logic [$clog2(RS_DEPTH):0] busy_count;
    idx_t free_idx;
    idx_t sel_idx;
    idx_t out_idx;
    logic sel_found;
    logic do_insert;
    logic do_issue;
    logic do_free;
    word_t op_a;
    word_t op_b;
    word_t alu_value;

    always_comb begin
        issue_ready = 1'b0;
        free_idx = '0;
        busy_count = '0;
        sel_found = 1'b0;
        sel_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                issue_ready = 1'b1;
                free_idx = idx_t'(i);
            end
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (busy[i]) begin
                busy_count = busy_count + 1'b1;
            end
            if (busy[i] && !issued[i] && station[i].operand[0].valid &&
                station[i].operand[1].valid && (!sel_found || rank[i] < rank[sel_idx])) begin
                sel_found = 1'b1;
                sel_idx = idx_t'(i);
            end
        end
    end

    assign id_taken = RS_OFFSET + rs_id_t'(free_idx);
    assign do_insert = issue_valid && issue_ready;
    assign do_issue = sel_found && (!out_valid || out_ready);
    assign do_free = out_valid && out_ready;

    assign op_a = station[sel_idx].operand[0].value;
    assign op_b = station[sel_idx].operand[1].value;

    always_comb begin
        if (UNIT == UNIT_ADD) begin
            // subf computes rB minus rA
            alu_value = (station[sel_idx].op == OP_SUBF) ? op_b - op_a : op_a + op_b;
        end else begin
            case (station[sel_idx].op)
                OP_AND: alu_value = op_a & op_b;
                OP_XOR: alu_value = op_a ^ op_b;
                default: alu_value = op_a | op_b;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                busy[i] <= 1'b0;
                issued[i] <= 1'b0;
                rank[i] <= '0;
            end
            out_valid <= 1'b0;
            out_idx <= '0;
        end else begin
            if (do_free) begin
                busy[out_idx] <= 1'b0;
                for (int i = 0; i < RS_DEPTH; i++) begin
                    if (busy[i] && rank[i] > rank[out_idx]) begin
                        rank[i] <= rank[i] - 1'b1;
                    end
                end
            end
            if (do_insert) begin
                busy[free_idx] <= 1'b1;
                issued[free_idx] <= 1'b0;
                rank[free_idx] <= idx_t'(busy_count - do_free);
            end
            if (do_issue) begin
                issued[sel_idx] <= 1'b1;
                out_idx <= sel_idx;
            end
            out_valid <= do_issue || (out_valid && !out_ready);
        end
    end

    always_ff @(posedge clk) begin
        if (do_insert) begin
            station[free_idx] <= issue;
        end
        // Snoop the result bus for waiting operands
        for (int i = 0; i < RS_DEPTH; i++) begin
            for (int k = 0; k < 2; k++) begin
                if (busy[i] && !station[i].operand[k].valid && result_valid &&
                    station[i].operand[k].rs_id == result.rs_id) begin
                    station[i].operand[k].value <= result.value;
                    station[i].operand[k].valid <= 1'b1;
                end
            end
        end
        if (do_issue) begin
            out_result.rs_id <= RS_OFFSET + rs_id_t'(sel_idx);
            out_result.dst <= station[sel_idx].dst;
            out_result.value <= alu_value;
        end
    end

endmodule

// ==== hdl/gp_reg_file.sv ====
// GPR file with pending-write tags, two read ports and result bus write
`timescale 1ns/100ps

module gp_reg_file (
    input  logic clk,
    input  logic rst_n,
    input  ppc_isa_pkg::gpr_addr_t rd_addr [2],
    output ppc_core_pkg::operand_t rd_operand [2],
    input  logic tag_enable,
    input  ppc_isa_pkg::gpr_addr_t tag_addr,
    input  ppc_core_pkg::rs_id_t tag_rs_id,
    input  logic result_valid,
    input  ppc_core_pkg::result_t result
);
    import ppc_isa_pkg::*;
    import ppc_core_pkg::*;

    word_t values [GPR_COUNT];
    logic pending [GPR_COUNT];
    rs_id_t tags [GPR_COUNT];

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rd_operand[i].value = values[rd_addr[i]];
            rd_operand[i].valid = !pending[rd_addr[i]];
            rd_operand[i].rs_id = tags[rd_addr[i]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < GPR_COUNT; r++) begin
                values[r] <= '0;
                pending[r] <= 1'b0;
                tags[r] <= '0;
            end
        end else begin
            // Only the latest producer in program order may write
            if (result_valid && pending[result.dst] && tags[result.dst] == result.rs_id) begin
                values[result.dst] <= result.value;
                pending[result.dst] <= 1'b0;
            end
            // A new dispatch overrides a completion to the same register
            if (tag_enable) begin
                pending[tag_addr] <= 1'b1;
                tags[tag_addr] <= tag_rs_id;
            end
        end
    end

endmodule

// ==== hdl/dispatcher.sv ====
// Unit steering, station tag update and operand selection with result bus bypass
`timescale 1ns/100ps

module dispatcher (
    input  logic decode_valid,
    output logic decode_ready,
    input  ppc_core_pkg::decode_t decode,
    output ppc_isa_pkg::gpr_addr_t rd_addr [2],
    input  ppc_core_pkg::operand_t rd_operand [2],
    output logic tag_enable,
    output ppc_isa_pkg::gpr_addr_t tag_addr,
    output ppc_core_pkg::rs_id_t tag_rs_id,
    input  logic result_valid,
    input  ppc_core_pkg::result_t result,
    output logic issue_valid [ppc_core_pkg::UNIT_COUNT],
    input  logic issue_ready [ppc_core_pkg::UNIT_COUNT],
    output ppc_core_pkg::issue_t issue,
    input  ppc_core_pkg::rs_id_t id_taken [ppc_core_pkg::UNIT_COUNT]
);
    import ppc_isa_pkg::*;
    import ppc_core_pkg::*;

    assign rd_addr[0] = decode.src_a;
    assign rd_addr[1] = decode.src_b;

    // Stall while the target unit has no free station
    assign decode_ready = issue_ready[decode.unit];

    // Destination now waits on the station being filled
    assign tag_enable = decode_valid && decode_ready;
    assign tag_addr = decode.dst;
    assign tag_rs_id = id_taken[decode.unit];

    always_comb begin
        for (int u = 0; u < UNIT_COUNT; u++) begin
            issue_valid[u] = decode_valid && (int'(decode.unit) == u);
        end
    end

    always_comb begin
        issue.op = decode.op;
        issue.dst = decode.dst;
        for (int i = 0; i < 2; i++) begin
            issue.operand[i] = rd_operand[i];
            if (decode.use_imm[i]) begin
                issue.operand[i].value = (i == 0) ? word_t'(0) : decode.imm;
                issue.operand[i].valid = 1'b1;
            end else if (!rd_operand[i].valid && result_valid &&
                         rd_operand[i].rs_id == result.rs_id) begin
                // Producer completes this cycle
                issue.operand[i].value = result.value;
                issue.operand[i].valid = 1'b1;
            end
        end
    end

endmodule

// ==== hdl/instruction_decode.sv ====
// Registered decode stage mapping instruction words onto unit, operation and operands
`timescale 1ns/100ps

module instruction_decode (
    input  logic clk,
    input  logic rst_n,
    input  logic instruction_valid,
    output logic instruction_ready,
    input  ppc_isa_pkg::word_t instruction,
    output logic decode_valid,
    input  logic decode_ready,
    output ppc_core_pkg::decode_t decode
);
    import ppc_isa_pkg::*;
    import ppc_core_pkg::*;

    opcd_t opcd;
    xo_t xo;
    logic supported;
    decode_t next_decode;

    assign opcd = instruction[0:5];
    assign xo = instruction[21:30];
    assign instruction_ready = !decode_valid || decode_ready;

    always_comb begin
        next_decode = '0;
        supported = 1'b1;
        // D and XO forms: rD, rA, rB
        next_decode.dst = instruction[6:10];
        next_decode.src_a = instruction[11:15];
        next_decode.src_b = instruction[16:20];
        case (opcd)
            OPCD_ADDI: begin
                next_decode.unit = UNIT_ADD;
                next_decode.op = OP_ADD;
                // rA of 0 means the literal zero, not GPR0
                next_decode.use_imm = {instruction[11:15] == 5'd0, 1'b1};
                next_decode.imm = {{16{instruction[16]}}, instruction[16:31]};
            end
            OPCD_ORI: begin
                next_decode.unit = UNIT_LOG;
                next_decode.op = OP_OR;
                next_decode.src_a = instruction[6:10];
                next_decode.dst = instruction[11:15];
                next_decode.use_imm = 2'b01;
                next_decode.imm = {16'h0000, instruction[16:31]};
            end
            OPCD_X: begin
                case (xo)
                    XO_ADD: begin
                        next_decode.unit = UNIT_ADD;
                        next_decode.op = OP_ADD;
                    end
                    XO_SUBF: begin
                        next_decode.unit = UNIT_ADD;
                        next_decode.op = OP_SUBF;
                    end
                    XO_AND, XO_OR, XO_XOR: begin
                        // Logical X form writes rA from rS and rB
                        next_decode.unit = UNIT_LOG;
                        next_decode.op = (xo == XO_AND) ? OP_AND :
                                         (xo == XO_OR) ? OP_OR : OP_XOR;
                        next_decode.src_a = instruction[6:10];
                        next_decode.dst = instruction[11:15];
                    end
                    default: supported = 1'b0;
                endcase
            end
            default: supported = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decode_valid <= 1'b0;
        end else if (instruction_ready) begin
            decode_valid <= instruction_valid && supported;
        end
    end

    always_ff @(posedge clk) begin
        if (instruction_valid && instruction_ready) begin
            decode <= next_decode;
        end
    end

endmodule

// ==== hdl/ppc_core_pkg.sv ====
// Station ID sizing, unit and ALU operation enums, decode, issue and result bus structs
package ppc_core_pkg;

    localparam int RS_DEPTH = 4;
    localparam int UNIT_COUNT = 2;
    localparam int RS_ID_WIDTH = 3;

    typedef logic [0:RS_ID_WIDTH-1] rs_id_t;

    // Each unit owns a contiguous block of station IDs
    localparam rs_id_t ADD_RS_OFFSET = 3'd0;
    localparam rs_id_t LOG_RS_OFFSET = 3'd4;

    // Order matches the unit index on the dispatch and arbiter arrays
    typedef enum logic {
        UNIT_ADD,
        UNIT_LOG
    } unit_e;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUBF,
        OP_AND,
        OP_OR,
        OP_XOR
    } alu_op_e;

    // Value when valid, otherwise the station ID that will produce it
    typedef struct packed {
        ppc_isa_pkg::word_t value;
        logic valid;
        rs_id_t rs_id;
    } operand_t;

    typedef struct packed {
        unit_e unit;
        alu_op_e op;
        ppc_isa_pkg::gpr_addr_t src_a;
        ppc_isa_pkg::gpr_addr_t src_b;
        ppc_isa_pkg::gpr_addr_t dst;
        // Index 0 selects a zero first operand, index 1 the immediate word
        logic [0:1] use_imm;
        ppc_isa_pkg::word_t imm;
    } decode_t;

    typedef struct packed {
        alu_op_e op;
        ppc_isa_pkg::gpr_addr_t dst;
        operand_t [0:1] operand;
    } issue_t;

    typedef struct packed {
        rs_id_t rs_id;
        ppc_isa_pkg::gpr_addr_t dst;
        ppc_isa_pkg::word_t value;
    } result_t;

endpackage

// ==== hdl/ppc_isa_pkg.sv ====
// PowerPC instruction field types, opcode encodings and GPR count
package ppc_isa_pkg;

    // Big-endian bit numbering as in the Power ISA books
    typedef logic [0:31] word_t;
    typedef logic [0:4] gpr_addr_t;
    typedef logic [0:5] opcd_t;
    typedef logic [0:9] xo_t;

    localparam int GPR_COUNT = 32;

    // Primary opcodes
    localparam opcd_t OPCD_ADDI = 6'd14;
    localparam opcd_t OPCD_ORI = 6'd24;
    localparam opcd_t OPCD_X = 6'd31;

    // Extended opcodes of the X/XO forms under primary opcode 31
    localparam xo_t XO_ADD = 10'd266;
    localparam xo_t XO_SUBF = 10'd40;
    localparam xo_t XO_AND = 10'd28;
    localparam xo_t XO_OR = 10'd444;
    localparam xo_t XO_XOR = 10'd316;

endpackage
